// File: source/raster_pkg.sv
package raster_pkg;

    // Edge setup and pixel coordinates
    typedef logic signed [15:0] coeff_t;
    typedef logic [15:0] coord_t;

    // Holds a*x + b*y + c for full-range inputs
    typedef logic signed [35:0] edge_val_t;

    // Bit 0 (x,y), bit 1 (x+1,y), bit 2 (x,y+1), bit 3 (x+1,y+1)
    typedef logic [3:0] mask_t;
    typedef logic [15:0] pid_t;

    // AXI4-Lite host port
    typedef logic [7:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // Register byte offsets, one edge per row of three
    localparam axi_addr_t REG_E0_A = 8'h00;
    localparam axi_addr_t REG_E0_B = 8'h04;
    localparam axi_addr_t REG_E0_C = 8'h08;
    localparam axi_addr_t REG_E1_A = 8'h0C;
    localparam axi_addr_t REG_E1_B = 8'h10;
    localparam axi_addr_t REG_E1_C = 8'h14;
    localparam axi_addr_t REG_E2_A = 8'h18;
    localparam axi_addr_t REG_E2_B = 8'h1C;
    localparam axi_addr_t REG_E2_C = 8'h20;

    // x in 15:0, y in 31:16
    localparam axi_addr_t REG_TILE = 8'h24;
    localparam axi_addr_t REG_PID = 8'h28;

    // Write bit 0 starts, read gives busy and queue not empty
    localparam axi_addr_t REG_CTRL = 8'h2C;

endpackage

// File: source/raster_csr.sv
`timescale 1ns/1ps

module raster_csr
    import raster_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    // AXI4-Lite write channels
    input  logic      awvalid,
    output logic      awready,
    input  axi_addr_t awaddr,
    input  logic      wvalid,
    output logic      wready,
    input  axi_data_t wdata,
    input  logic [3:0] wstrb,
    output logic      bvalid,
    input  logic      bready,
    output axi_resp_t bresp,
    // AXI4-Lite read channels
    input  logic      arvalid,
    output logic      arready,
    input  axi_addr_t araddr,
    output logic      rvalid,
    input  logic      rready,
    output axi_data_t rdata,
    output axi_resp_t rresp,
    // Status from walker and queue
    input  logic      busy,
    input  logic      nonempty,
    // Command to walker
    output logic      start,
    output coeff_t    e0_a,
    output coeff_t    e0_b,
    output coeff_t    e0_c,
    output coeff_t    e1_a,
    output coeff_t    e1_b,
    output coeff_t    e1_c,
    output coeff_t    e2_a,
    output coeff_t    e2_b,
    output coeff_t    e2_c,
    output coord_t    tile_x,
    output coord_t    tile_y,
    output pid_t      pid
);

    logic wr_fire;
    logic wr_commit;
    logic rd_fire;
    axi_data_t rd_data;
    axi_resp_t rd_resp;

    function automatic axi_data_t sext(coeff_t v);
        return {{16{v[15]}}, v};
    endfunction

    // Word aligned and inside the register window
    function automatic logic is_mapped(axi_addr_t addr);
        return (addr[1:0] == 2'b00) && (addr <= REG_CTRL);
    endfunction

    assign wr_fire = awready && awvalid && wvalid;
    // Partial strobes are accepted but change nothing
    assign wr_commit = wr_fire && (wstrb == 4'hF);
    assign rd_fire = arready && arvalid;

    assign start = wr_commit && (awaddr == REG_CTRL) && wdata[0] && !busy;

    // Handshake state
    always_ff @(posedge clk) begin
        if (reset) begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            arready <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !bvalid && !awready;
            wready <= awvalid && wvalid && !bvalid && !awready;
            arready <= arvalid && !rvalid && !arready;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= is_mapped(awaddr) ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_fire) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

    // Register file
    always_ff @(posedge clk) begin
        if (reset) begin
            e0_a <= '0;
            e0_b <= '0;
            e0_c <= '0;
            e1_a <= '0;
            e1_b <= '0;
            e1_c <= '0;
            e2_a <= '0;
            e2_b <= '0;
            e2_c <= '0;
            tile_x <= '0;
            tile_y <= '0;
            pid <= '0;
        end else if (wr_commit) begin
            case (awaddr)
                REG_E0_A: e0_a <= wdata[15:0];
                REG_E0_B: e0_b <= wdata[15:0];
                REG_E0_C: e0_c <= wdata[15:0];
                REG_E1_A: e1_a <= wdata[15:0];
                REG_E1_B: e1_b <= wdata[15:0];
                REG_E1_C: e1_c <= wdata[15:0];
                REG_E2_A: e2_a <= wdata[15:0];
                REG_E2_B: e2_b <= wdata[15:0];
                REG_E2_C: e2_c <= wdata[15:0];
                REG_TILE: begin
                    tile_x <= wdata[15:0];
                    tile_y <= wdata[31:16];
                end
                REG_PID: pid <= wdata[15:0];
                default: ;
            endcase
        end
    end

    // Read mux, unmapped offsets give zero data
    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (araddr)
            REG_E0_A: rd_data = sext(e0_a);
            REG_E0_B: rd_data = sext(e0_b);
            REG_E0_C: rd_data = sext(e0_c);
            REG_E1_A: rd_data = sext(e1_a);
            REG_E1_B: rd_data = sext(e1_b);
            REG_E1_C: rd_data = sext(e1_c);
            REG_E2_A: rd_data = sext(e2_a);
            REG_E2_B: rd_data = sext(e2_b);
            REG_E2_C: rd_data = sext(e2_c);
            REG_TILE: rd_data = {tile_y, tile_x};
            REG_PID: rd_data = {16'h0000, pid};
            REG_CTRL: rd_data = {30'd0, nonempty, busy};
            default: rd_resp = RESP_SLVERR;
        endcase
    end

endmodule

// File: source/raster_quad_walker.sv
`timescale 1ns/1ps

module raster_quad_walker
    import raster_pkg::*;
#(
    parameter int TILE_SIZE = 8
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   start,
    input  coeff_t e0_a,
    input  coeff_t e0_b,
    input  coeff_t e0_c,
    input  coeff_t e1_a,
    input  coeff_t e1_b,
    input  coeff_t e1_c,
    input  coeff_t e2_a,
    input  coeff_t e2_b,
    input  coeff_t e2_c,
    input  coord_t tile_x,
    input  coord_t tile_y,
    input  pid_t   pid,
    input  logic   full,
    output logic   busy,
    output logic   push_valid,
    output coord_t push_x,
    output coord_t push_y,
    output mask_t  push_mask,
    output pid_t   push_pid
);

    localparam int QUADS = TILE_SIZE / 2;
    localparam int CW = $clog2(TILE_SIZE);

    typedef enum logic {IDLE, WALK} walk_state_t;

    walk_state_t state;
    logic [CW-1:0] qx;
    logic [CW-1:0] qy;
    logic advance;
    logic row_end;
    logic last_quad;

    coeff_t a_in [3];
    coeff_t b_in [3];
    coeff_t c_in [3];
    coeff_t a_r [3];
    coeff_t b_r [3];
    coord_t tile_x_r;
    coord_t tile_y_r;
    pid_t pid_r;

    // Edge values at the current quad origin and at its row start
    edge_val_t cur_val [3];
    edge_val_t row_val [3];
    edge_val_t origin_val [3];
    mask_t mask;

    function automatic edge_val_t edge_at(coeff_t a, coeff_t b, coeff_t c,
                                          coord_t x, coord_t y);
        edge_val_t ax;
        edge_val_t by;
        ax = edge_val_t'(a) * edge_val_t'(x);
        by = edge_val_t'(b) * edge_val_t'(y);
        return ax + by + edge_val_t'(c);
    endfunction

    assign a_in = '{e0_a, e1_a, e2_a};
    assign b_in = '{e0_b, e1_b, e2_b};
    assign c_in = '{e0_c, e1_c, e2_c};

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            origin_val[i] = edge_at(a_in[i], b_in[i], c_in[i], tile_x, tile_y);
        end
    end

    // A pixel is covered when no edge value is negative
    always_comb begin
        edge_val_t ea;
        edge_val_t eb;
        mask = 4'hF;
        for (int i = 0; i < 3; i++) begin
            ea = edge_val_t'(a_r[i]);
            eb = edge_val_t'(b_r[i]);
            if (cur_val[i] < 0) mask[0] = 1'b0;
            if (cur_val[i] + ea < 0) mask[1] = 1'b0;
            if (cur_val[i] + eb < 0) mask[2] = 1'b0;
            if (cur_val[i] + ea + eb < 0) mask[3] = 1'b0;
        end
    end

    assign busy = (state == WALK);
    assign advance = busy && !full;
    assign row_end = (qx == CW'(QUADS - 1));
    assign last_quad = row_end && (qy == CW'(QUADS - 1));

    assign push_valid = advance && (mask != 4'h0);
    assign push_x = tile_x_r + coord_t'({qx, 1'b0});
    assign push_y = tile_y_r + coord_t'({qy, 1'b0});
    assign push_mask = mask;
    assign push_pid = pid_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            qx <= '0;
            qy <= '0;
        end else if (state == IDLE) begin
            if (start) begin
                state <= WALK;
                qx <= '0;
                qy <= '0;
            end
        end else if (advance) begin
            if (last_quad) begin
                state <= IDLE;
            end
            if (row_end) begin
                qx <= '0;
                qy <= qy + 1'b1;
            end else begin
                qx <= qx + 1'b1;
            end
        end
    end

    // Command snapshot and incremental edge stepping
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            a_r <= a_in;
            b_r <= b_in;
            tile_x_r <= tile_x;
            tile_y_r <= tile_y;
            pid_r <= pid;
            cur_val <= origin_val;
            row_val <= origin_val;
        end else if (advance) begin
            for (int i = 0; i < 3; i++) begin
                if (row_end) begin
                    // Two pixel rows down
                    row_val[i] <= row_val[i] + (edge_val_t'(b_r[i]) <<< 1);
                    cur_val[i] <= row_val[i] + (edge_val_t'(b_r[i]) <<< 1);
                end else begin
                    cur_val[i] <= cur_val[i] + (edge_val_t'(a_r[i]) <<< 1);
                end
            end
        end
    end

endmodule

// File: source/raster_quad_queue.sv
`timescale 1ns/1ps

module raster_quad_queue
    import raster_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   push_valid,
    input  coord_t push_x,
    input  coord_t push_y,
    input  mask_t  push_mask,
    input  pid_t   push_pid,
    input  logic   quad_ready,
    output logic   full,
    output logic   nonempty,
    output logic   quad_valid,
    output coord_t quad_x,
    output coord_t quad_y,
    output mask_t  quad_mask,
    output pid_t   quad_pid
);

    localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNTW = $clog2(QUEUE_DEPTH + 1);

    coord_t x_mem [QUEUE_DEPTH];
    coord_t y_mem [QUEUE_DEPTH];
    mask_t mask_mem [QUEUE_DEPTH];
    pid_t pid_mem [QUEUE_DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CNTW-1:0] count;
    logic do_push;
    logic do_pop;

    function automatic logic [PW-1:0] next_ptr(logic [PW-1:0] ptr);
        return (ptr == PW'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == CNTW'(QUEUE_DEPTH));
    assign quad_valid = (count != '0);
    assign nonempty = quad_valid;

    assign do_push = push_valid && !full;
    assign do_pop = quad_valid && quad_ready;

    // Head entry is the stream output
    assign quad_x = x_mem[rd_ptr];
    assign quad_y = y_mem[rd_ptr];
    assign quad_mask = mask_mem[rd_ptr];
    assign quad_pid = pid_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            x_mem[wr_ptr] <= push_x;
            y_mem[wr_ptr] <= push_y;
            mask_mem[wr_ptr] <= push_mask;
            pid_mem[wr_ptr] <= push_pid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            // Simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: source/raster_unit.sv
`timescale 1ns/1ps

module raster_unit
    import raster_pkg::*;
#(
    parameter int TILE_SIZE = 8,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       awvalid,
    output logic       awready,
    input  axi_addr_t  awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  axi_data_t  wdata,
    input  logic [3:0] wstrb,
    output logic       bvalid,
    input  logic       bready,
    output axi_resp_t  bresp,
    input  logic       arvalid,
    output logic       arready,
    input  axi_addr_t  araddr,
    output logic       rvalid,
    input  logic       rready,
    output axi_data_t  rdata,
    output axi_resp_t  rresp,
    output logic       quad_valid,
    input  logic       quad_ready,
    output coord_t     quad_x,
    output coord_t     quad_y,
    output mask_t      quad_mask,
    output pid_t       quad_pid
);

    // Command snapshot buses
    logic start;
    coeff_t e0_a, e0_b, e0_c;
    coeff_t e1_a, e1_b, e1_c;
    coeff_t e2_a, e2_b, e2_c;
    coord_t tile_x, tile_y;
    pid_t pid;
    logic busy;
    logic nonempty;

    // Walker to queue
    logic push_valid;
    coord_t push_x, push_y;
    mask_t push_mask;
    pid_t push_pid;
    logic full;

    raster_csr csr (
        .clk(clk), .reset(reset),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .busy(busy), .nonempty(nonempty), .start(start),
        .e0_a(e0_a), .e0_b(e0_b), .e0_c(e0_c),
        .e1_a(e1_a), .e1_b(e1_b), .e1_c(e1_c),
        .e2_a(e2_a), .e2_b(e2_b), .e2_c(e2_c),
        .tile_x(tile_x), .tile_y(tile_y), .pid(pid)
    );

    raster_quad_walker #(
        .TILE_SIZE(TILE_SIZE)
    ) walker (
        .clk(clk), .reset(reset), .start(start),
        .e0_a(e0_a), .e0_b(e0_b), .e0_c(e0_c),
        .e1_a(e1_a), .e1_b(e1_b), .e1_c(e1_c),
        .e2_a(e2_a), .e2_b(e2_b), .e2_c(e2_c),
        .tile_x(tile_x), .tile_y(tile_y), .pid(pid),
        .full(full), .busy(busy),
        .push_valid(push_valid), .push_x(push_x), .push_y(push_y),
        .push_mask(push_mask), .push_pid(push_pid)
    );

    raster_quad_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) queue (
        .clk(clk), .reset(reset),
        .push_valid(push_valid), .push_x(push_x), .push_y(push_y),
        .push_mask(push_mask), .push_pid(push_pid),
        .quad_ready(quad_ready), .full(full), .nonempty(nonempty),
        .quad_valid(quad_valid), .quad_x(quad_x), .quad_y(quad_y),
        .quad_mask(quad_mask), .quad_pid(quad_pid)
    );

endmodule

// File: test/raster_checker.sv
`timescale 1ns/1ps

module raster_checker
    import raster_pkg::*;
#(
    parameter int TILE_SIZE = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       awvalid,
    input  logic       awready,
    input  axi_addr_t  awaddr,
    input  logic       wvalid,
    input  logic       wready,
    input  axi_data_t  wdata,
    input  logic [3:0] wstrb,
    input  logic       bvalid,
    input  logic       bready,
    input  axi_resp_t  bresp,
    input  logic       arvalid,
    input  logic       arready,
    input  axi_addr_t  araddr,
    input  logic       rvalid,
    input  logic       rready,
    input  axi_data_t  rdata,
    input  axi_resp_t  rresp,
    input  logic       quad_valid,
    input  logic       quad_ready,
    input  coord_t     quad_x,
    input  coord_t     quad_y,
    input  mask_t      quad_mask,
    input  pid_t       quad_pid,
    input  logic       expect_ignore,
    output int         errors,
    output int         outstanding
);

    // Packed as {x, y, mask, pid}
    typedef logic [51:0] quad_t;

    // Host view of the register file
    coeff_t coef [9];
    coord_t tile_x;
    coord_t tile_y;
    pid_t pid;

    quad_t expected [$];
    quad_t got;
    quad_t want;
    quad_t hold_quad;
    logic hold_valid;
    axi_resp_t exp_bresp;
    axi_data_t exp_rdata;
    axi_resp_t exp_rresp;
    // Live busy and nonempty bits cannot be predicted
    logic exp_status;
    int idx;

    function automatic logic is_register(axi_addr_t addr);
        case (addr)
            REG_E0_A, REG_E0_B, REG_E0_C,
            REG_E1_A, REG_E1_B, REG_E1_C,
            REG_E2_A, REG_E2_B, REG_E2_C,
            REG_TILE, REG_PID, REG_CTRL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic pixel_covered(int px, int py);
        longint e;
        pixel_covered = 1'b1;
        for (int i = 0; i < 3; i++) begin
            e = longint'(coef[3 * i]) * px + longint'(coef[3 * i + 1]) * py
                + longint'(coef[3 * i + 2]);
            if (e < 0) begin
                pixel_covered = 1'b0;
            end
        end
    endfunction

    // Reference model of one tile in row-major quad order
    function automatic void add_expected_quads();
        mask_t m;
        int x;
        int y;
        for (int qy = 0; qy < TILE_SIZE; qy += 2) begin
            for (int qx = 0; qx < TILE_SIZE; qx += 2) begin
                x = int'(tile_x) + qx;
                y = int'(tile_y) + qy;
                m[0] = pixel_covered(x, y);
                m[1] = pixel_covered(x + 1, y);
                m[2] = pixel_covered(x, y + 1);
                m[3] = pixel_covered(x + 1, y + 1);
                if (m != 4'h0) begin
                    expected.push_back({coord_t'(x), coord_t'(y), m, pid});
                end
            end
        end
    endfunction

    function automatic void set_read_expectation(axi_addr_t addr);
        exp_status = 1'b0;
        exp_rresp = RESP_OKAY;
        exp_rdata = '0;
        if (!is_register(addr)) begin
            exp_rresp = RESP_SLVERR;
        end else if (addr <= REG_E2_C) begin
            exp_rdata = axi_data_t'(coef[int'(addr) / 4]);
        end else if (addr == REG_TILE) begin
            exp_rdata = {tile_y, tile_x};
        end else if (addr == REG_PID) begin
            exp_rdata = {16'h0000, pid};
        end else begin
            exp_status = 1'b1;
        end
    endfunction

    function automatic void report_mismatch(string name, longint unsigned exp_val,
                                            longint unsigned act_val);
        $display("Mismatch at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp_val, act_val);
        errors++;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 9; i++) begin
                coef[i] = '0;
            end
            tile_x = '0;
            tile_y = '0;
            pid = '0;
            expected.delete();
            hold_valid = 1'b0;
            errors = 0;
        end else begin
            // Check responses before taking new requests
            if (bvalid && bready && bresp !== exp_bresp) begin
                report_mismatch("bresp", 64'(exp_bresp), 64'(bresp));
            end
            if (rvalid && rready) begin
                if (rresp !== exp_rresp) begin
                    report_mismatch("rresp", 64'(exp_rresp), 64'(rresp));
                end
                if (exp_status && rdata[31:2] !== 30'd0) begin
                    report_mismatch("rdata[31:2]", 64'd0, 64'(rdata[31:2]));
                end else if (!exp_status && rdata !== exp_rdata) begin
                    report_mismatch("rdata", 64'(exp_rdata), 64'(rdata));
                end
            end

            // Address and data channels are accepted on the same cycle
            if (wready !== awready) begin
                $display("Error at %0t: wready and awready did not pulse together", $time);
                errors++;
            end

            if (awvalid && awready && wvalid && wready) begin
                exp_bresp = is_register(awaddr) ? RESP_OKAY : RESP_SLVERR;
                if (is_register(awaddr) && wstrb == 4'hF) begin
                    if (awaddr <= REG_E2_C) begin
                        idx = int'(awaddr) / 4;
                        coef[idx] = wdata[15:0];
                    end else if (awaddr == REG_TILE) begin
                        tile_x = wdata[15:0];
                        tile_y = wdata[31:16];
                    end else if (awaddr == REG_PID) begin
                        pid = wdata[15:0];
                    end else if (wdata[0] && !expect_ignore) begin
                        add_expected_quads();
                    end
                end
            end
            if (arvalid && arready) begin
                set_read_expectation(araddr);
            end

            // Stream must hold still until accepted
            got = {quad_x, quad_y, quad_mask, quad_pid};
            if (hold_valid && !quad_valid) begin
                $display("Error at %0t: quad_valid dropped before the quad was accepted", $time);
                errors++;
            end else if (hold_valid && got !== hold_quad) begin
                $display("Error at %0t: quad stream data changed while waiting for quad_ready",
                         $time);
                errors++;
            end
            if (quad_valid && quad_ready) begin
                if (expected.size() == 0) begin
                    $display("Error at %0t: quad at (%0d,%0d) arrived when none was expected",
                             $time, quad_x, quad_y);
                    errors++;
                end else begin
                    want = expected.pop_front();
                    if (quad_x !== want[51:36]) begin
                        report_mismatch("quad_x", 64'(want[51:36]), 64'(quad_x));
                    end
                    if (quad_y !== want[35:20]) begin
                        report_mismatch("quad_y", 64'(want[35:20]), 64'(quad_y));
                    end
                    if (quad_mask !== want[19:16]) begin
                        report_mismatch("quad_mask", 64'(want[19:16]), 64'(quad_mask));
                    end
                    if (quad_pid !== want[15:0]) begin
                        report_mismatch("quad_pid", 64'(want[15:0]), 64'(quad_pid));
                    end
                end
            end
            hold_valid = quad_valid && !quad_ready;
            hold_quad = got;
        end
        outstanding = expected.size();
    end

endmodule

// File: test/raster_tb.sv
`timescale 1ns/1ps

module raster_tb
    import raster_pkg::*;
();

    localparam int TILE_SIZE = 8;
    localparam int QUEUE_DEPTH = 4;
    localparam int NUM_TILES = 10;
    localparam int QUADS_PER_TILE = (TILE_SIZE / 2) * (TILE_SIZE / 2);
    localparam int CYCLE_LIMIT = NUM_TILES * QUADS_PER_TILE * 4 + 2000;

    logic clk;
    logic reset;
    logic awvalid;
    logic awready;
    axi_addr_t awaddr;
    logic wvalid;
    logic wready;
    axi_data_t wdata;
    logic [3:0] wstrb;
    logic bvalid;
    logic bready;
    axi_resp_t bresp;
    logic arvalid;
    logic arready;
    axi_addr_t araddr;
    logic rvalid;
    logic rready;
    axi_data_t rdata;
    axi_resp_t rresp;
    logic quad_valid;
    logic quad_ready;
    coord_t quad_x;
    coord_t quad_y;
    mask_t quad_mask;
    pid_t quad_pid;

    logic expect_ignore;
    // 0 always ready, 1 random, 2 held low
    logic [1:0] ready_mode;
    integer seed;
    integer ready_seed;
    integer ready_rnd;
    int cycle_count;
    int tb_errors;
    int check_errors;
    int outstanding;

    raster_unit #(
        .TILE_SIZE(TILE_SIZE),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) UUT (
        .clk(clk), .reset(reset),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .quad_valid(quad_valid), .quad_ready(quad_ready), .quad_x(quad_x),
        .quad_y(quad_y), .quad_mask(quad_mask), .quad_pid(quad_pid)
    );

    raster_checker #(
        .TILE_SIZE(TILE_SIZE)
    ) scoreboard (
        .clk(clk), .reset(reset),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .quad_valid(quad_valid), .quad_ready(quad_ready), .quad_x(quad_x),
        .quad_y(quad_y), .quad_mask(quad_mask), .quad_pid(quad_pid),
        .expect_ignore(expect_ignore), .errors(check_errors), .outstanding(outstanding)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            quad_ready <= 1'b0;
        end else if (ready_mode == 2'd0) begin
            quad_ready <= 1'b1;
        end else if (ready_mode == 2'd1) begin
            ready_rnd = $random(ready_seed);
            quad_ready <= ready_rnd[0];
        end else begin
            quad_ready <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic axi_write(input axi_addr_t addr, input axi_data_t data,
                             input logic [3:0] strb);
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr <= addr;
        wvalid <= 1'b1;
        wdata <= data;
        wstrb <= strb;
        bready <= 1'b1;
        do @(posedge clk); while (!awready);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        do @(posedge clk); while (!bvalid);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
        @(posedge clk);
        arvalid <= 1'b1;
        araddr <= addr;
        rready <= 1'b1;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        do @(posedge clk); while (!rvalid);
        data = rdata;
        rready <= 1'b0;
    endtask

    // Idle means walker done and queue drained
    task automatic wait_idle();
        axi_data_t status;
        status = 32'h3;
        while (status[1:0] != 2'b00) begin
            axi_read(REG_CTRL, status);
        end
    endtask

    task automatic set_edge(input int idx, input int a, input int b, input int c);
        axi_write(REG_E0_A + axi_addr_t'(12 * idx), axi_data_t'(a), 4'hF);
        axi_write(REG_E0_B + axi_addr_t'(12 * idx), axi_data_t'(b), 4'hF);
        axi_write(REG_E0_C + axi_addr_t'(12 * idx), axi_data_t'(c), 4'hF);
    endtask

    task automatic run_tile(input coord_t tx, input coord_t ty, input pid_t id);
        axi_write(REG_TILE, {ty, tx}, 4'hF);
        axi_write(REG_PID, {16'h0000, id}, 4'hF);
        axi_write(REG_CTRL, 32'h1, 4'hF);
        wait_idle();
    endtask

    task automatic random_triangle(input coord_t tx, input coord_t ty, input pid_t id);
        int px;
        int py;
        int a;
        int b;
        int c;
        // All three edges keep one pixel of the tile inside
        px = int'(tx) + int'({$random(seed)} % TILE_SIZE);
        py = int'(ty) + int'({$random(seed)} % TILE_SIZE);
        for (int i = 0; i < 3; i++) begin
            a = int'({$random(seed)} % 16) - 8;
            b = int'({$random(seed)} % 16) - 8;
            c = int'({$random(seed)} % 12) - (a * px + b * py);
            set_edge(i, a, b, c);
        end
        run_tile(tx, ty, id);
    endtask

    initial begin
        int value;
        axi_data_t rd;
        reset = 1'b1;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = 4'h0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        quad_ready = 1'b0;
        expect_ignore = 1'b0;
        ready_mode = 2'd0;
        seed = 32'hfbd0;
        ready_seed = 32'hfbd0;
        cycle_count = 0;
        tb_errors = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // Register readback with junk in the upper data bits
        for (int i = 0; i < 9; i++) begin
            value = (i % 2 == 0) ? -(i * 1000 + 123) : (i * 3000 + 45);
            axi_write(axi_addr_t'(4 * i), {16'hA5A5, value[15:0]}, 4'hF);
        end
        axi_write(REG_TILE, 32'h0030_0010, 4'hF);
        axi_write(REG_PID, 32'h0000_BEEF, 4'hF);
        axi_write(REG_PID, 32'h0000_1234, 4'h3);
        for (int i = 0; i < 11; i++) begin
            axi_read(axi_addr_t'(4 * i), rd);
        end

        // Unmapped offsets
        axi_write(8'h30, 32'h1111_2222, 4'hF);
        axi_write(8'h06, 32'h3333_4444, 4'hF);
        axi_read(8'h30, rd);
        axi_read(8'hFC, rd);
        axi_read(8'h0A, rd);

        // Whole tile covered
        set_edge(0, 1, 0, 0);
        set_edge(1, 0, 1, 0);
        set_edge(2, 0, 0, 5);
        run_tile(16'd0, 16'd0, 16'd1);

        random_triangle(16'd8, 16'd0, 16'd11);
        random_triangle(16'd16, 16'd24, 16'd12);
        random_triangle(16'd40, 16'd8, 16'd13);
        random_triangle(16'd0, 16'd40, 16'd14);

        ready_mode <= 2'd1;
        random_triangle(16'd24, 16'd16, 16'd21);
        random_triangle(16'd8, 16'd32, 16'd22);
        random_triangle(16'd32, 16'd0, 16'd23);
        random_triangle(16'd0, 16'd8, 16'd24);

        // Redundant start while the walker stalls on a full queue
        ready_mode <= 2'd2;
        set_edge(0, 1, 0, 0);
        set_edge(1, 0, 1, 0);
        set_edge(2, 0, 0, 5);
        axi_write(REG_TILE, {16'd8, 16'd8}, 4'hF);
        axi_write(REG_PID, 32'h0000_0031, 4'hF);
        axi_write(REG_CTRL, 32'h1, 4'hF);
        axi_read(REG_CTRL, rd);
        if (rd[1:0] !== 2'b11) begin
            $display("Error at %0t: status did not show busy and queue not empty %s",
                     $time, "before the second start");
            tb_errors++;
        end
        @(posedge clk);
        expect_ignore <= 1'b1;
        axi_write(REG_CTRL, 32'h1, 4'hF);
        expect_ignore <= 1'b0;
        ready_mode <= 2'd0;
        wait_idle();

        repeat (4) @(posedge clk);
        if (outstanding != 0) begin
            $display("Error: %0d expected quads never appeared on the stream", outstanding);
        end
        $display("Errors: %0d checker, %0d testbench, %0d quads outstanding",
                 check_errors, tb_errors, outstanding);
        if (check_errors == 0 && tb_errors == 0 && outstanding == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
source/raster_pkg.sv
source/raster_csr.sv
source/raster_quad_walker.sv
source/raster_quad_queue.sv
source/raster_unit.sv
test/raster_checker.sv
test/raster_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module raster_tb -f vlog.f -o raster_sim \
    && ./obj_dir/raster_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0
